/* src/wfd_pkg.sv */
`default_nettype none

package wfd_pkg;

	////////////////////////////////////////
	// Trigger token and FIFO entry
	////////////////////////////////////////
	localparam int TOKEN_W = 10;
	typedef logic [TOKEN_W-1:0] token_t;

	typedef struct packed {
		logic   err;	// Parity error seen on the line
		token_t tok;
	} tok_entry_t;

	////////////////////////////////////////
	// Gigabit link words
	////////////////////////////////////////
	localparam int GTP_W = 16;
	typedef logic [GTP_W-1:0] gtp_word_t;

	localparam gtp_word_t  COMMA_WORD = 16'h00BC;	// K28.5 idle
	localparam logic [4:0] TOKEN_TAG  = 5'b10000;	// Marks a token word

	////////////////////////////////////////
	// APB register map
	////////////////////////////////////////
	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] csr_word_t;

	localparam apb_addr_t ADDR_CTRL    = 4'h0;
	localparam apb_addr_t ADDR_TOKCNT  = 4'h4;
	localparam apb_addr_t ADDR_STATUS  = 4'h8;
	localparam apb_addr_t ADDR_VERSION = 4'hC;

	localparam csr_word_t VERSION_WORD = 32'h0125_0103;

	localparam int LED_N = 3;	// Front panel LEDs

endpackage

`default_nettype wire

/* src/trig_token_rcv.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_token_rcv (
	input  wire            CLK125,
	input  wire            rst_i,
	input  wire            ser_trig_i,	// Serial trigger, idles low
	output wfd_pkg::token_t tok_o,
	output logic           tok_rdy_o,
	output logic           tok_err_o
);
	import wfd_pkg::*;

	logic               busy;	// Inside a frame
	logic [3:0]         bit_cnt;	// Bits taken after the start bit
	logic [TOKEN_W-1:0] shreg;	// Token bits, MSB first

	////////////////////////////////////////
	// Start hunt and bit gathering
	////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			busy      <= 1'b0;
			bit_cnt   <= '0;
			tok_rdy_o <= 1'b0;
		end else begin
			tok_rdy_o <= 1'b0;	// Ready is a single pulse
			if (!busy) begin
				bit_cnt <= '0;
				if (ser_trig_i)	// Start bit
					busy <= 1'b1;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
				shreg   <= {shreg[TOKEN_W-2:0], ser_trig_i};
				// Eleventh bit is parity, frame done
				if (bit_cnt == 4'(TOKEN_W)) begin
					busy      <= 1'b0;
					tok_rdy_o <= 1'b1;
					tok_o     <= shreg;
					tok_err_o <= ~^{shreg, ser_trig_i};	// Odd parity expected
				end
			end
		end
	end

	// Frames are 12 cycles at least, so ready never repeats at once
	a_rdy_single: assert property (@(posedge CLK125) disable iff (rst_i)
		tok_rdy_o |=> !tok_rdy_o)
		else $error("tok_rdy_o high in two consecutive cycles");

endmodule

`default_nettype wire

/* src/token_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module token_fifo #(
	parameter int FIFO_DEPTH = 8	// Power of two
) (
	input  wire                  CLK125,
	input  wire                  rst_i,
	input  wire                  push_i,
	input  wfd_pkg::tok_entry_t  push_data_i,
	input  wire                  pop_i,
	output wfd_pkg::tok_entry_t  head_o,
	output logic                 empty_o,
	output logic                 overflow_o
);
	import wfd_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	tok_entry_t  mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr;	// Extra MSB tells full from empty
	logic [AW:0] rd_ptr;
	logic        full;

	assign empty_o = (wr_ptr == rd_ptr);
	assign full    = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});
	assign head_o  = mem[rd_ptr[AW-1:0]];	// Head shown ahead of pop

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (push_i && !full)
			mem[wr_ptr[AW-1:0]] <= push_data_i;
	end

	////////////////////////////////////////
	// Pointers and overflow pulse
	////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (push_i && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			overflow_o <= push_i & full;	// Entry dropped
		end
	end

	// Consumer must look at empty_o before popping
	a_no_pop_empty: assert property (@(posedge CLK125) disable iff (rst_i)
		pop_i |-> !empty_o)
		else $error("pop while token FIFO empty");

endmodule

`default_nettype wire

/* src/gtp_token_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module gtp_token_tx (
	input  wire                  CLK125,
	input  wire                  rst_i,
	input  wire                  empty_i,
	input  wfd_pkg::tok_entry_t  head_i,
	input  wire                  enable_i,	// From CTRL
	input  wire                  inhibit_i,	// From CTRL
	output logic                 pop_o,
	output wfd_pkg::gtp_word_t   gtp_word_o,
	output logic                 gtp_kchar_o
);
	import wfd_pkg::*;

	// Send only with a token waiting and the host allowing it
	assign pop_o = !empty_i && enable_i && !inhibit_i;

	////////////////////////////////////////
	// Registered link word
	////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			gtp_word_o  <= COMMA_WORD;
			gtp_kchar_o <= 1'b1;
		end else if (pop_o) begin
			gtp_word_o  <= {TOKEN_TAG, head_i};	// Tag, error flag, token
			gtp_kchar_o <= 1'b0;	// Data character
		end else begin
			// Keep the link aligned with commas
			gtp_word_o  <= COMMA_WORD;
			gtp_kchar_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/csr_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_apb (
	input  wire                 CLK125,
	input  wire                 rst_i,
	input  wire                 psel_i,
	input  wire                 penable_i,
	input  wire                 pwrite_i,
	input  wfd_pkg::apb_addr_t  paddr_i,
	input  wfd_pkg::csr_word_t  pwdata_i,
	output wfd_pkg::csr_word_t  prdata_o,
	output logic                pslverr_o,
	input  wire                 tok_rdy_i,
	input  wire                 tok_err_i,
	input  wire                 overflow_i,
	input  wire                 fifo_empty_i,
	output logic                enable_o,
	output logic                inhibit_o
);
	import wfd_pkg::*;

	logic        access;	// APB access phase
	logic        bad_addr;
	logic        ro_write;	// Write to a read-only register
	logic        wr_ok;
	logic [15:0] good_cnt;
	logic [15:0] err_cnt;
	logic        ovf_flag;	// Sticky overflow

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////
	assign access   = psel_i & penable_i;
	assign bad_addr = !(paddr_i inside {ADDR_CTRL, ADDR_TOKCNT, ADDR_STATUS, ADDR_VERSION});
	assign ro_write = pwrite_i && (paddr_i == ADDR_TOKCNT || paddr_i == ADDR_VERSION);
	assign pslverr_o = access & (bad_addr | ro_write);
	assign wr_ok     = access & pwrite_i & !bad_addr & !ro_write;

	always_comb begin
		case (paddr_i)
			ADDR_CTRL:    prdata_o = {30'd0, inhibit_o, enable_o};
			ADDR_TOKCNT:  prdata_o = {err_cnt, good_cnt};
			ADDR_STATUS:  prdata_o = {30'd0, fifo_empty_i, ovf_flag};
			ADDR_VERSION: prdata_o = VERSION_WORD;
			default:      prdata_o = '0;
		endcase
	end

	////////////////////////////////////////
	// Registers and counters
	////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			enable_o  <= 1'b0;
			inhibit_o <= 1'b0;
			good_cnt  <= '0;
			err_cnt   <= '0;
			ovf_flag  <= 1'b0;
		end else begin
			if (wr_ok && paddr_i == ADDR_CTRL) begin
				enable_o  <= pwdata_i[0];
				inhibit_o <= pwdata_i[1];
			end
			// Saturating token counters
			if (tok_rdy_i && !tok_err_i && good_cnt != 16'hFFFF)
				good_cnt <= good_cnt + 16'd1;
			if (tok_rdy_i && tok_err_i && err_cnt != 16'hFFFF)
				err_cnt <= err_cnt + 16'd1;
			// New overflow wins over a clear in the same cycle
			if (overflow_i)
				ovf_flag <= 1'b1;
			else if (wr_ok && paddr_i == ADDR_STATUS && pwdata_i[0])
				ovf_flag <= 1'b0;
		end
	end

	// Access phase must follow a setup phase
	a_apb_setup: assert property (@(posedge CLK125) disable iff (rst_i)
		penable_i |-> psel_i && $past(psel_i && !penable_i))
		else $error("APB access without setup phase");

endmodule

`default_nettype wire

/* src/led_stretch.sv */
`timescale 1ns/1ps
`default_nettype none

module led_stretch #(
	parameter int LED_STRETCH = 8	// Lit cycles after the event ends
) (
	input  wire  CLK125,
	input  wire  rst_i,
	input  wire  event_i,
	output logic led_o
);
	localparam int CW = $clog2(LED_STRETCH + 1);

	logic [CW-1:0] cnt;	// Cycles left to stay lit

	always_ff @(posedge CLK125) begin
		if (rst_i)
			cnt <= '0;
		else if (event_i)
			cnt <= CW'(LED_STRETCH);	// Reload while active
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

	assign led_o = (cnt != '0);

endmodule

`default_nettype wire

/* src/trig_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_link_top #(
	parameter int FIFO_DEPTH  = 8,
	parameter int LED_STRETCH = 8
) (
	input  wire                        CLK125,
	input  wire                        rst_i,
	input  wire                        ser_trig_i,
	// APB from the host
	input  wire                        psel_i,
	input  wire                        penable_i,
	input  wire                        pwrite_i,
	input  wfd_pkg::apb_addr_t         paddr_i,
	input  wfd_pkg::csr_word_t         pwdata_i,
	output wfd_pkg::csr_word_t         prdata_o,
	output logic                       pslverr_o,
	// Gigabit link transmit word
	output wfd_pkg::gtp_word_t         gtp_word_o,
	output logic                       gtp_kchar_o,
	output logic [wfd_pkg::LED_N-1:0]  led_o
);
	import wfd_pkg::*;

	token_t           tok;
	logic             tok_rdy;
	logic             tok_err;
	tok_entry_t       push_entry;
	tok_entry_t       head;
	logic             fifo_empty;
	logic             overflow;
	logic             pop;
	logic             enable;
	logic             inhibit;
	logic [LED_N-1:0] led_event;

	assign push_entry = {tok_err, tok};

	////////////////////////////////////////
	// Token path
	////////////////////////////////////////
	trig_token_rcv i_rcv (
		.CLK125(CLK125), .rst_i(rst_i), .ser_trig_i(ser_trig_i),
		.tok_o(tok), .tok_rdy_o(tok_rdy), .tok_err_o(tok_err)
	);

	token_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
		.CLK125(CLK125), .rst_i(rst_i),
		.push_i(tok_rdy), .push_data_i(push_entry), .pop_i(pop),	// No back-pressure
		.head_o(head), .empty_o(fifo_empty), .overflow_o(overflow)
	);

	gtp_token_tx i_tx (
		.CLK125(CLK125), .rst_i(rst_i),
		.empty_i(fifo_empty), .head_i(head), .enable_i(enable), .inhibit_i(inhibit),
		.pop_o(pop), .gtp_word_o(gtp_word_o), .gtp_kchar_o(gtp_kchar_o)
	);

	////////////////////////////////////////
	// Host registers
	////////////////////////////////////////
	csr_apb i_csr (
		.CLK125(CLK125), .rst_i(rst_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.prdata_o(prdata_o), .pslverr_o(pslverr_o),
		.tok_rdy_i(tok_rdy), .tok_err_i(tok_err),
		.overflow_i(overflow), .fifo_empty_i(fifo_empty),
		.enable_o(enable), .inhibit_o(inhibit)
	);

	// LED 0 yellow error, LED 1 token seen, LED 2 no inhibit
	assign led_event[0] = (tok_rdy & tok_err) | overflow;
	assign led_event[1] = tok_rdy;
	assign led_event[2] = ~inhibit;

	for (genvar i = 0; i < LED_N; i++) begin : g_led
		led_stretch #(.LED_STRETCH(LED_STRETCH)) i_led (
			.CLK125(CLK125), .rst_i(rst_i),
			.event_i(led_event[i]), .led_o(led_o[i])
		);
	end

endmodule

`default_nettype wire

/* tests/tb_trig_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trig_link;
	import wfd_pkg::*;

	typedef struct packed {
		token_t tok;
		logic   corrupt;	// Flip the parity bit
		logic   exp_err;
	} row_t;

	localparam int   N_ROWS = 6;
	localparam row_t STIM [N_ROWS] = '{
		'{10'h000, 1'b0, 1'b0},
		'{10'h3FF, 1'b0, 1'b0},
		'{10'h155, 1'b1, 1'b1},
		'{10'h2AA, 1'b0, 1'b0},
		'{10'h001, 1'b1, 1'b1},
		'{10'h3C3, 1'b0, 1'b0}
	};

	// Rows, inhibit burst and two LED frames at worst-case frame plus gap
	localparam int FRAME_LEN   = TOKEN_W + 2;
	localparam int MAX_GAP     = 5;
	localparam int N_FRAMES    = N_ROWS + 6 + 2;
	localparam int TIMEOUT_CYC = 2 * N_FRAMES * (FRAME_LEN + MAX_GAP) + 500;

	logic             CLK125 = 1'b0;
	logic             rst_i;
	logic             ser_trig_i;
	logic             psel_i;
	logic             penable_i;
	logic             pwrite_i;
	apb_addr_t        paddr_i;
	csr_word_t        pwdata_i;
	csr_word_t        prdata_o;
	logic             pslverr_o;
	gtp_word_t        gtp_word_o;
	logic             gtp_kchar_o;
	logic [LED_N-1:0] led_o;

	int        cyc = 0;	// Cycle number for timing checks and the watchdog
	gtp_word_t rx_q [$];	// Token words seen on the link
	int        rx_cyc [$];

	trig_link_top #(.FIFO_DEPTH(4), .LED_STRETCH(8)) i_trig_link_top (
		.CLK125(CLK125), .rst_i(rst_i), .ser_trig_i(ser_trig_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.prdata_o(prdata_o), .pslverr_o(pslverr_o),
		.gtp_word_o(gtp_word_o), .gtp_kchar_o(gtp_kchar_o), .led_o(led_o)
	);

	always #10 CLK125 = ~CLK125;	// 50 MHz in sim

	always @(posedge CLK125) begin
		cyc <= cyc + 1;
		if (cyc > TIMEOUT_CYC) begin
			$display("Timeout: DUT did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Test failed");
			$fatal(1, "watchdog expired");
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	task automatic report_fail(input string msg);
		$display("[FAIL] %0d ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_word(input gtp_word_t got, input gtp_word_t exp, input string what);
		if (got !== exp)
			report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_csr(input csr_word_t got, input csr_word_t exp, input string what);
		if (got !== exp)
			report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_fail($sformatf("%s: got %b, expected %b", what, got, exp));
	endtask

	// Link monitor checks every comma and queues data words
	always @(negedge CLK125) begin
		if (!rst_i) begin
			if (gtp_kchar_o)
				check_word(gtp_word_o, COMMA_WORD, "idle comma");
			else begin
				rx_q.push_back(gtp_word_o);
				rx_cyc.push_back(cyc);
			end
		end
	end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK125);
			#2;
		end
	endtask

	task automatic at_cycle(input int n);	// Returns at the negedge of cycle n
		@(negedge CLK125);
		while (cyc < n)
			@(negedge CLK125);
	endtask

	task automatic send_frame(input token_t tok, input logic corrupt, output int s);
		logic             par;
		logic [TOKEN_W:0] bits;
		par  = ~^tok ^ corrupt;	// Odd parity over token and parity bit
		bits = {tok, par};
		s = cyc;
		ser_trig_i = 1'b1;	// Start bit
		idle(1);
		for (int i = TOKEN_W; i >= 0; i--) begin
			ser_trig_i = bits[i];	// MSB first
			idle(1);
		end
		ser_trig_i = 1'b0;
	endtask

	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input csr_word_t wdata,
			output csr_word_t rdata, output logic err);
		psel_i    = 1'b1;	// Setup phase
		penable_i = 1'b0;
		pwrite_i  = wr;
		paddr_i   = addr;
		pwdata_i  = wdata;
		idle(1);
		penable_i = 1'b1;	// Access phase without wait states
		@(negedge CLK125);
		rdata = prdata_o;
		err   = pslverr_o;
		idle(1);
		psel_i    = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input csr_word_t data, output logic err);
		csr_word_t unused_rd;
		apb_xfer(1'b1, addr, data, unused_rd, err);
	endtask

	task automatic apb_read(input apb_addr_t addr, output csr_word_t data, output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	task automatic wait_words(input int n);
		while (rx_q.size() < n)
			@(posedge CLK125);
		#2;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		csr_word_t   rd;
		logic        err;
		int          s;
		int          s_first;
		int          c;
		logic [15:0] n_good;
		logic [15:0] n_err;
		token_t      burst [6];
		void'($urandom(59));
		rst_i      = 1'b1;
		ser_trig_i = 1'b0;
		psel_i     = 1'b0;
		penable_i  = 1'b0;
		pwrite_i   = 1'b0;
		paddr_i    = '0;
		pwdata_i   = '0;
		repeat (2) @(posedge CLK125);
		#2 rst_i = 1'b0;

		// Reset state
		@(negedge CLK125);
		check_word(gtp_word_o, COMMA_WORD, "word after reset");
		check_bit(gtp_kchar_o, 1'b1, "k-flag after reset");
		for (int i = 0; i < LED_N; i++)
			check_bit(led_o[i], 1'b0, $sformatf("LED %0d after reset", i));
		idle(1);
		apb_read(ADDR_CTRL, rd, err);
		check_csr(rd, 32'h0, "CTRL after reset");
		apb_read(ADDR_TOKCNT, rd, err);
		check_csr(rd, 32'h0, "TOKCNT after reset");
		apb_read(ADDR_STATUS, rd, err);
		check_csr(rd, 32'h2, "STATUS after reset");	// Only empty set
		check_bit(err, 1'b0, "pslverr on STATUS read");

		// Table rows with random gaps
		apb_write(ADDR_CTRL, 32'h1, err);
		rx_q.delete();
		rx_cyc.delete();
		n_good = '0;
		n_err  = '0;
		for (int i = 0; i < N_ROWS; i++) begin
			send_frame(STIM[i].tok, STIM[i].corrupt, s);
			if (i == 0)
				s_first = s;
			if (STIM[i].corrupt)
				n_err++;
			else
				n_good++;
			idle($urandom_range(0, MAX_GAP));
		end
		wait_words(N_ROWS);
		idle(20);
		if (rx_q.size() != N_ROWS)
			report_fail($sformatf("saw %0d token words, expected %0d", rx_q.size(), N_ROWS));
		for (int i = 0; i < N_ROWS; i++)
			check_word(rx_q[i], {TOKEN_TAG, STIM[i].exp_err, STIM[i].tok},
				$sformatf("token word %0d", i));
		if (rx_cyc[0] != s_first + 14)
			report_fail($sformatf("first word in cycle %0d, expected %0d",
				rx_cyc[0], s_first + 14));
		apb_read(ADDR_TOKCNT, rd, err);
		check_csr(rd, {n_err, n_good}, "TOKCNT after table");

		// Inhibit holds the FIFO until extra tokens overflow
		apb_write(ADDR_CTRL, 32'h3, err);
		rx_q.delete();
		rx_cyc.delete();
		for (int i = 0; i < 6; i++) begin
			burst[i] = token_t'(10'h040 + i);
			send_frame(burst[i], 1'b0, s);
			idle($urandom_range(0, MAX_GAP));
		end
		idle(20);
		if (rx_q.size() != 0)
			report_fail("token words sent while inhibited");
		apb_read(ADDR_STATUS, rd, err);
		check_csr(rd, 32'h1, "STATUS with overflow");
		apb_write(ADDR_CTRL, 32'h1, err);	// Release
		wait_words(4);
		idle(20);
		if (rx_q.size() != 4)
			report_fail($sformatf("released %0d tokens, expected 4", rx_q.size()));
		for (int i = 0; i < 4; i++)
			check_word(rx_q[i], {TOKEN_TAG, 1'b0, burst[i]}, $sformatf("released word %0d", i));
		apb_write(ADDR_STATUS, 32'h1, err);
		apb_read(ADDR_STATUS, rd, err);
		check_csr(rd, 32'h2, "STATUS after overflow clear");

		// Version and bus errors
		apb_read(ADDR_VERSION, rd, err);
		check_csr(rd, VERSION_WORD, "VERSION");
		check_bit(err, 1'b0, "pslverr on VERSION read");
		apb_write(ADDR_VERSION, 32'hDEAD_BEEF, err);
		check_bit(err, 1'b1, "pslverr on VERSION write");
		apb_read(apb_addr_t'(4'h6), rd, err);
		check_bit(err, 1'b1, "pslverr on unmapped read");
		apb_read(ADDR_CTRL, rd, err);
		check_csr(rd, 32'h1, "CTRL after bus errors");

		////////////////////////////////////////
		// LED stretching
		////////////////////////////////////////
		send_frame(10'h0F0, 1'b0, s);
		at_cycle(s + 12);
		check_bit(led_o[1], 1'b0, "LED 1 before token");
		at_cycle(s + 13);
		check_bit(led_o[1], 1'b1, "LED 1 rise");
		at_cycle(s + 20);
		check_bit(led_o[1], 1'b1, "LED 1 held");
		at_cycle(s + 21);
		check_bit(led_o[1], 1'b0, "LED 1 fall");
		idle(1);
		send_frame(10'h0F0, 1'b1, s);	// Parity error
		at_cycle(s + 12);
		check_bit(led_o[0], 1'b0, "LED 0 before error");
		at_cycle(s + 13);
		check_bit(led_o[0], 1'b1, "LED 0 rise");
		at_cycle(s + 20);
		check_bit(led_o[0], 1'b1, "LED 0 held");
		at_cycle(s + 21);
		check_bit(led_o[0], 1'b0, "LED 0 fall");
		idle(1);
		check_bit(led_o[2], 1'b1, "LED 2 with inhibit off");
		apb_write(ADDR_CTRL, 32'h3, err);
		c = cyc;
		at_cycle(c + 9);
		check_bit(led_o[2], 1'b0, "LED 2 with inhibit on");
		idle(1);
		apb_write(ADDR_CTRL, 32'h1, err);
		c = cyc;
		at_cycle(c + 1);
		check_bit(led_o[2], 1'b1, "LED 2 after inhibit cleared");

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
src/wfd_pkg.sv
src/trig_token_rcv.sv
src/token_fifo.sv
src/gtp_token_tx.sv
src/csr_apb.sv
src/led_stretch.sv
src/trig_link_top.sv
tests/tb_trig_link.sv

/* Makefile */
TOP := tb_trig_link

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f src/*.sv tests/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir
